/* include/bios_loader_cfg.svh */
//////////////////////////////////////////////////////////////////////
// firmware image loader configuration
// bus and download widths, write strobe timing,
// segment prefixes for the BIOS and option ROM images
//////////////////////////////////////////////////////////////////////

`ifndef BIOS_LOADER_CFG_SVH
`define BIOS_LOADER_CFG_SVH

// system address space, 1 MB
`define BIOS_ADDR_W 20

// download channel
`define LOAD_ADDR_W 25
`define INDEX_W 8

// memory cycle timing in clk_chipset cycles
`define WRITE_PULSE_CYCLES 20
`define RECOVER_CYCLES 20

// must hold pulse plus recovery
`define TIMER_W 6

// top 64 KB segment for PC/XT and Tandy BIOS
`define ROM_SEGMENT 4'hF

// XT-IDE option ROM at EC000
`define XTIDE_PREFIX 6'b111011

`endif

/* hw/bios_loader_pkg.sv */
//////////////////////////////////////////////////////////////////////
// shared types of the firmware image loader
// load sequencer states, image selection, system address and byte
//////////////////////////////////////////////////////////////////////

`include "bios_loader_cfg.svh"

package bios_loader_pkg;

    // load sequencer states
    typedef enum logic [1:0]
    {
        IDLE,
        ACCEPT,
        WRITE,
        RECOVER
    } load_state_t;

    // which ROM image a download byte belongs to
    typedef enum logic [1:0]
    {
        IMAGE_NONE,
        IMAGE_PCXT,
        IMAGE_TANDY,
        IMAGE_XTIDE
    } image_sel_t;

    typedef logic [`BIOS_ADDR_W-1:0] bios_addr_t;
    typedef logic [7:0] bios_byte_t;

endpackage

/* hw/bios_load_fsm.sv */
//////////////////////////////////////////////////////////////////////
// load sequencer for the firmware image loader
// bus request and BIOS protect control, byte acceptance with
// wait back-pressure, write strobe and recovery sequencing
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module bios_load_fsm
(
    input  logic clk_chipset,
    input  logic reset,
    input  logic ioctl_download,
    input  logic ioctl_wr,
    input  logic bus_granted,
    input  logic mem_ready,
    input  logic image_valid,
    input  logic pulse_done,
    input  logic recover_done,
    output logic ioctl_wait,
    output logic bios_access_request,
    output logic bios_protect_flag,
    output logic mem_write_n,
    output logic capture,
    output logic data_release,
    output logic timer_start
);

    bios_loader_pkg::load_state_t state;
    logic accept_byte;

    // a strobe is only taken while wait is low
    assign accept_byte = (state == bios_loader_pkg::ACCEPT) &&
                         ioctl_download &&
                         ioctl_wr &&
                         image_valid &&
                         !ioctl_wait &&
                         mem_ready;

    // address map and timer both start on the accepted byte
    assign capture     = accept_byte;
    assign timer_start = accept_byte;

    // end of pulse, or memory dropping out under us
    assign data_release = !mem_ready ||
                          ((state == bios_loader_pkg::WRITE) && pulse_done);

    //////////////////////////////////////////////////////////////////////
    // state and registered control outputs
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_chipset, posedge reset)
    begin
        if (reset)
        begin
            state               <= bios_loader_pkg::IDLE;
            ioctl_wait          <= 1'b0;
            bios_access_request <= 1'b0;
            bios_protect_flag   <= 1'b1;
            mem_write_n         <= 1'b1;
        end
        else if (!mem_ready)
        begin
            // memory not initialised, hold everything at rest
            state               <= bios_loader_pkg::IDLE;
            ioctl_wait          <= 1'b0;
            bios_access_request <= 1'b0;
            bios_protect_flag   <= 1'b1;
            mem_write_n         <= 1'b1;
        end
        else
        begin
            case (state)
                bios_loader_pkg::IDLE:
                begin
                    bios_protect_flag <= 1'b1;
                    mem_write_n       <= 1'b1;
                    if (ioctl_download && bus_granted)
                    begin
                        // CPU is off the bus, open for bytes
                        state               <= bios_loader_pkg::ACCEPT;
                        bios_access_request <= 1'b1;
                        bios_protect_flag   <= 1'b0;
                        ioctl_wait          <= 1'b0;
                    end
                    else
                    begin
                        // request the bus and stall the source meanwhile
                        bios_access_request <= ioctl_download;
                        ioctl_wait          <= ioctl_download;
                    end
                end

                bios_loader_pkg::ACCEPT:
                begin
                    bios_access_request <= 1'b1;
                    bios_protect_flag   <= 1'b0;
                    if (!ioctl_download)
                    begin
                        // download finished
                        state               <= bios_loader_pkg::IDLE;
                        bios_access_request <= 1'b0;
                        bios_protect_flag   <= 1'b1;
                        ioctl_wait          <= 1'b0;
                        mem_write_n         <= 1'b1;
                    end
                    else if (accept_byte)
                    begin
                        state       <= bios_loader_pkg::WRITE;
                        ioctl_wait  <= 1'b1;
                        mem_write_n <= 1'b0;
                    end
                    else
                    begin
                        // no strobe, or a byte for no known image
                        ioctl_wait  <= 1'b0;
                        mem_write_n <= 1'b1;
                    end
                end

                bios_loader_pkg::WRITE:
                begin
                    ioctl_wait <= 1'b1;
                    if (pulse_done)
                    begin
                        state       <= bios_loader_pkg::RECOVER;
                        mem_write_n <= 1'b1;
                    end
                    else
                    begin
                        mem_write_n <= 1'b0;
                    end
                end

                bios_loader_pkg::RECOVER:
                begin
                    mem_write_n <= 1'b1;
                    if (recover_done)
                    begin
                        // byte done, let the source continue
                        state      <= bios_loader_pkg::ACCEPT;
                        ioctl_wait <= 1'b0;
                    end
                    else
                    begin
                        ioctl_wait <= 1'b1;
                    end
                end

                default:
                begin
                    state               <= bios_loader_pkg::IDLE;
                    ioctl_wait          <= 1'b0;
                    bios_access_request <= 1'b0;
                    bios_protect_flag   <= 1'b1;
                    mem_write_n         <= 1'b1;
                end
            endcase
        end
    end

endmodule

/* hw/bios_write_timer.sv */
//////////////////////////////////////////////////////////////////////
// memory cycle timer for the firmware image loader
// one up counter covering write pulse and recovery gap,
// single cycle done flags at the end of each phase
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "bios_loader_cfg.svh"

module bios_write_timer
(
    input  logic clk_chipset,
    input  logic reset,
    input  logic timer_start,
    output logic pulse_done,
    output logic recover_done
);

    localparam logic [`TIMER_W-1:0] pulse_last =
        `TIMER_W'(`WRITE_PULSE_CYCLES - 1);
    localparam logic [`TIMER_W-1:0] count_end =
        `TIMER_W'(`WRITE_PULSE_CYCLES + `RECOVER_CYCLES);
    localparam logic [`TIMER_W-1:0] recover_last = count_end - 1'b1;

    logic [`TIMER_W-1:0] count;

    // parked at count_end when idle so no flag fires
    always_ff @(posedge clk_chipset, posedge reset)
    begin
        if (reset)
        begin
            count <= count_end;
        end
        else if (timer_start)
        begin
            count <= '0;
        end
        else if (count != count_end)
        begin
            count <= count + 1'b1;
        end
    end

    // last cycle of each phase
    assign pulse_done   = (count == pulse_last);
    assign recover_done = (count == recover_last);

endmodule

/* hw/bios_address_map.sv */
//////////////////////////////////////////////////////////////////////
// image decode and address mapping for the firmware image loader
// PC/XT, Tandy and XT-IDE image select from index and load address,
// held memory address, data byte and Tandy mark for one write
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "bios_loader_cfg.svh"

module bios_address_map
(
    input  logic                          clk_chipset,
    input  logic                          reset,
    input  logic [`INDEX_W-1:0]           ioctl_index,
    input  logic [`LOAD_ADDR_W-1:0]       ioctl_addr,
    input  bios_loader_pkg::bios_byte_t   ioctl_data,
    input  logic                          capture,
    input  logic                          data_release,
    output logic                          image_valid,
    output bios_loader_pkg::bios_addr_t   mem_address,
    output bios_loader_pkg::bios_byte_t   mem_data,
    output logic                          tandy_bios_write
);

    bios_loader_pkg::image_sel_t  image_sel;
    bios_loader_pkg::bios_addr_t  mapped_address;
    logic                         below_64k;

    //////////////////////////////////////////////////////////////////////
    // image decode
    //////////////////////////////////////////////////////////////////////

    // BIOS images are at most one segment long
    assign below_64k = (ioctl_addr[`LOAD_ADDR_W-1:16] == '0);

    always_comb
    begin
        if ((ioctl_index < `INDEX_W'(2)) && below_64k)
        begin
            image_sel = bios_loader_pkg::IMAGE_PCXT;
        end
        else if ((ioctl_index == `INDEX_W'(2)) && below_64k)
        begin
            image_sel = bios_loader_pkg::IMAGE_TANDY;
        end
        else if (ioctl_index == `INDEX_W'(3))
        begin
            // option ROM, upper bits are simply dropped
            image_sel = bios_loader_pkg::IMAGE_XTIDE;
        end
        else
        begin
            image_sel = bios_loader_pkg::IMAGE_NONE;
        end
    end

    assign image_valid = (image_sel != bios_loader_pkg::IMAGE_NONE);

    // both BIOS flavours land in F000, option ROM at EC00
    always_comb
    begin
        case (image_sel)
            bios_loader_pkg::IMAGE_PCXT,
            bios_loader_pkg::IMAGE_TANDY:
                mapped_address = {`ROM_SEGMENT, ioctl_addr[15:0]};
            bios_loader_pkg::IMAGE_XTIDE:
                mapped_address = {`XTIDE_PREFIX, ioctl_addr[13:0]};
            default:
                mapped_address = '1;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // write cycle registers
    //////////////////////////////////////////////////////////////////////

    // bus idles at all ones between writes
    always_ff @(posedge clk_chipset, posedge reset)
    begin
        if (reset)
        begin
            mem_address      <= '1;
            mem_data         <= '1;
            tandy_bios_write <= 1'b0;
        end
        else if (data_release)
        begin
            mem_address      <= '1;
            mem_data         <= '1;
            tandy_bios_write <= 1'b0;
        end
        else if (capture)
        begin
            mem_address      <= mapped_address;
            mem_data         <= ioctl_data;
            tandy_bios_write <= (image_sel == bios_loader_pkg::IMAGE_TANDY);
        end
    end

endmodule

/* hw/bios_loader_top.sv */
//////////////////////////////////////////////////////////////////////
// firmware image loader top level
// download channel in, system memory write cycles out
// load sequencer, cycle timer and address map
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "bios_loader_cfg.svh"

module bios_loader_top
(
    input  logic                          clk_chipset,
    input  logic                          reset,
    input  logic                          ioctl_download,
    input  logic [`INDEX_W-1:0]           ioctl_index,
    input  logic [`LOAD_ADDR_W-1:0]       ioctl_addr,
    input  logic                          ioctl_wr,
    input  bios_loader_pkg::bios_byte_t   ioctl_data,
    input  logic                          bus_granted,
    input  logic                          mem_ready,
    output logic                          ioctl_wait,
    output logic                          bios_access_request,
    output logic                          bios_protect_flag,
    output bios_loader_pkg::bios_addr_t   mem_address,
    output bios_loader_pkg::bios_byte_t   mem_data,
    output logic                          mem_write_n,
    output logic                          tandy_bios_write
);

    // sequencer to timer and address map
    logic timer_start;
    logic capture;
    logic data_release;

    // back to the sequencer
    logic pulse_done;
    logic recover_done;
    logic image_valid;

    bios_load_fsm u_load_fsm
    (
        .clk_chipset         (clk_chipset),
        .reset               (reset),
        .ioctl_download      (ioctl_download),
        .ioctl_wr            (ioctl_wr),
        .bus_granted         (bus_granted),
        .mem_ready           (mem_ready),
        .image_valid         (image_valid),
        .pulse_done          (pulse_done),
        .recover_done        (recover_done),
        .ioctl_wait          (ioctl_wait),
        .bios_access_request (bios_access_request),
        .bios_protect_flag   (bios_protect_flag),
        .mem_write_n         (mem_write_n),
        .capture             (capture),
        .data_release        (data_release),
        .timer_start         (timer_start)
    );

    bios_write_timer u_write_timer
    (
        .clk_chipset  (clk_chipset),
        .reset        (reset),
        .timer_start  (timer_start),
        .pulse_done   (pulse_done),
        .recover_done (recover_done)
    );

    bios_address_map u_address_map
    (
        .clk_chipset      (clk_chipset),
        .reset            (reset),
        .ioctl_index      (ioctl_index),
        .ioctl_addr       (ioctl_addr),
        .ioctl_data       (ioctl_data),
        .capture          (capture),
        .data_release     (data_release),
        .image_valid      (image_valid),
        .mem_address      (mem_address),
        .mem_data         (mem_data),
        .tandy_bios_write (tandy_bios_write)
    );

endmodule

/* test/bios_loader_asserts.sv */
//////////////////////////////////////////////////////////////////////
// concurrent assertions on the memory side of the image loader
// strobe qualification, held address and data, strobe length
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "bios_loader_cfg.svh"

module bios_loader_asserts
(
    input logic                          clk_chipset,
    input logic                          reset,
    input logic                          ioctl_wait,
    input logic                          bios_access_request,
    input logic                          bios_protect_flag,
    input bios_loader_pkg::bios_addr_t   mem_address,
    input bios_loader_pkg::bios_byte_t   mem_data,
    input logic                          mem_write_n
);

    logic [7:0] low_run;
    int grant_failures = 0;
    int hold_failures = 0;
    int length_failures = 0;

    // length of the current low run of the strobe
    always_ff @(posedge clk_chipset, posedge reset)
    begin
        if (reset)
            low_run <= '0;
        else if (mem_write_n)
            low_run <= '0;
        else if (low_run != 8'hFF)
            low_run <= low_run + 8'd1;
    end

    // bus held and source stalled for any write
    write_qualified: assert property (@(posedge clk_chipset) disable iff (reset)
        !mem_write_n |-> (bios_access_request && !bios_protect_flag && ioctl_wait))
    else
    begin
        grant_failures++;
        $error("write strobe without bus request, open protect flag and wait");
    end

    address_data_held: assert property (@(posedge clk_chipset) disable iff (reset)
        (!mem_write_n && !$past(mem_write_n)) |-> ($stable(mem_address) && $stable(mem_data)))
    else
    begin
        hold_failures++;
        $error("mem_address or mem_data changed during the write strobe");
    end

    strobe_length: assert property (@(posedge clk_chipset) disable iff (reset)
        $rose(mem_write_n) |-> (low_run == 8'(`WRITE_PULSE_CYCLES)))
    else
    begin
        length_failures++;
        $error("write strobe low run of %0d cycles", low_run);
    end

endmodule

bind bios_loader_top bios_loader_asserts u_asserts
(
    .clk_chipset         (clk_chipset),
    .reset               (reset),
    .ioctl_wait          (ioctl_wait),
    .bios_access_request (bios_access_request),
    .bios_protect_flag   (bios_protect_flag),
    .mem_address         (mem_address),
    .mem_data            (mem_data),
    .mem_write_n         (mem_write_n)
);

/* test/bios_loader_tb.sv */
//////////////////////////////////////////////////////////////////////
// testbench for the firmware image loader
// directed tests for reset values, image mapping, rejected bytes,
// bus gating and an LFSR driven byte stream
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "bios_loader_cfg.svh"

module bios_loader_tb;

    localparam int byte_cycles = `WRITE_PULSE_CYCLES + `RECOVER_CYCLES + 8;
    localparam int num_random = 16;
    // one memory cycle per directed and random byte plus margin
    localparam int cycle_limit = (num_random + 12) * byte_cycles + 400;

    logic                        clk_chipset;
    logic                        reset;
    logic                        ioctl_download;
    logic [`INDEX_W-1:0]         ioctl_index;
    logic [`LOAD_ADDR_W-1:0]     ioctl_addr;
    logic                        ioctl_wr;
    bios_loader_pkg::bios_byte_t ioctl_data;
    logic                        bus_granted;
    logic                        mem_ready;
    logic                        ioctl_wait;
    logic                        bios_access_request;
    logic                        bios_protect_flag;
    bios_loader_pkg::bios_addr_t mem_address;
    bios_loader_pkg::bios_byte_t mem_data;
    logic                        mem_write_n;
    logic                        tandy_bios_write;

    int checks;
    int errors;
    int assert_errors;
    int cycle_count;
    logic [15:0] lfsr;

    bios_loader_top dut (.*);

    initial
    begin
        clk_chipset = 1'b0;
        forever #20 clk_chipset = ~clk_chipset;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected)
        begin
            errors++;
            $display("mismatch %s: got %h, expected %h", name, got, expected);
        end
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("%s", what);
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    // BIOS images go to the top segment and the option ROM to EC000
    function automatic bios_loader_pkg::bios_addr_t expected_address(
        input logic [`INDEX_W-1:0] index, input logic [`LOAD_ADDR_W-1:0] addr);
        if (index == `INDEX_W'(3))
            return 20'hEC000 | {6'b0, addr[13:0]};
        return 20'hF0000 | {4'b0, addr[15:0]};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // download channel helpers
    //////////////////////////////////////////////////////////////////////

    task automatic await_accept();
        int waited;
        waited = 0;
        @(negedge clk_chipset);
        while (ioctl_wait && waited < byte_cycles)
        begin
            @(negedge clk_chipset);
            waited++;
        end
        if (ioctl_wait)
            report_failure("ioctl_wait stayed high, loader never took the next byte");
    endtask

    task automatic send_strobe(input logic [`INDEX_W-1:0] index,
                               input logic [`LOAD_ADDR_W-1:0] addr,
                               input bios_loader_pkg::bios_byte_t data);
        @(posedge clk_chipset);
        ioctl_index <= index;
        ioctl_addr  <= addr;
        ioctl_data  <= data;
        ioctl_wr    <= 1'b1;
        @(posedge clk_chipset);
        ioctl_wr <= 1'b0;
    endtask

    // one accepted byte with strobe contents and length checked
    task automatic write_byte(input logic [`INDEX_W-1:0] index,
                              input logic [`LOAD_ADDR_W-1:0] addr,
                              input bios_loader_pkg::bios_byte_t data);
        int low_cycles;
        int waited;
        low_cycles = 0;
        waited = 0;
        await_accept();
        send_strobe(index, addr, data);
        @(negedge clk_chipset);
        while (mem_write_n && waited < 4)
        begin
            @(negedge clk_chipset);
            waited++;
        end
        if (mem_write_n)
        begin
            report_failure("no write strobe after a valid byte");
        end
        else
        begin
            check_value("mem_address", 32'(mem_address), 32'(expected_address(index, addr)));
            check_value("mem_data", 32'(mem_data), 32'(data));
            check_value("tandy_bios_write", 32'(tandy_bios_write),
                        32'(index == `INDEX_W'(2)));
            while (!mem_write_n)
            begin
                low_cycles++;
                @(negedge clk_chipset);
            end
            check_value("mem_write_n low cycles", 32'(low_cycles), `WRITE_PULSE_CYCLES);
            check_value("mem_address after strobe", 32'(mem_address), 32'hFFFFF);
            check_value("mem_data after strobe", 32'(mem_data), 32'hFF);
            check_value("tandy_bios_write after strobe", 32'(tandy_bios_write), 0);
        end
        await_accept();
    endtask

    // strobe that must not start a memory cycle
    task automatic reject_byte(input logic [`INDEX_W-1:0] index,
                               input logic [`LOAD_ADDR_W-1:0] addr,
                               input bios_loader_pkg::bios_byte_t data,
                               input logic exp_wait);
        int low_cycles;
        int wait_errors;
        low_cycles = 0;
        wait_errors = 0;
        send_strobe(index, addr, data);
        repeat (8)
        begin
            @(negedge clk_chipset);
            if (!mem_write_n)
                low_cycles++;
            if (ioctl_wait !== exp_wait)
                wait_errors++;
        end
        check_value("mem_write_n low cycles on rejected byte", 32'(low_cycles), 0);
        check_value("ioctl_wait wrong cycles on rejected byte", 32'(wait_errors), 0);
    endtask

    task automatic start_download();
        int waited;
        waited = 0;
        @(posedge clk_chipset);
        ioctl_download <= 1'b1;
        @(negedge clk_chipset);
        while (bios_protect_flag && waited < 8)
        begin
            @(negedge clk_chipset);
            waited++;
        end
        if (bios_protect_flag)
            report_failure("protect flag stayed high after the download started");
        check_value("bios_access_request", 32'(bios_access_request), 1);
    endtask

    task automatic end_download();
        @(posedge clk_chipset);
        ioctl_download <= 1'b0;
        repeat (2) @(negedge clk_chipset);
        check_value("bios_access_request", 32'(bios_access_request), 0);
        check_value("bios_protect_flag", 32'(bios_protect_flag), 1);
        check_value("ioctl_wait", 32'(ioctl_wait), 0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic reset_values();
        @(negedge clk_chipset);
        check_value("mem_write_n", 32'(mem_write_n), 1);
        check_value("bios_access_request", 32'(bios_access_request), 0);
        check_value("bios_protect_flag", 32'(bios_protect_flag), 1);
        check_value("ioctl_wait", 32'(ioctl_wait), 0);
        check_value("mem_address", 32'(mem_address), 32'hFFFFF);
        check_value("mem_data", 32'(mem_data), 32'hFF);
        check_value("tandy_bios_write", 32'(tandy_bios_write), 0);
    endtask

    task automatic image_mapping();
        start_download();
        write_byte(8'd0, 25'h0001234, 8'h5A);
        write_byte(8'd2, 25'h000BEEF, 8'hC3);
        write_byte(8'd3, 25'h1ABCDEF, 8'h7E);
    endtask

    task automatic rejected_bytes();
        // index 1 above 64 KB, then an unknown index
        reject_byte(8'd1, 25'h0010000, 8'h11, 1'b0);
        reject_byte(8'd5, 25'h0000100, 8'h22, 1'b0);
        write_byte(8'd1, 25'h000FFFF, 8'h33);
        end_download();
    endtask

    task automatic bus_gating();
        @(posedge clk_chipset);
        bus_granted    <= 1'b0;
        ioctl_download <= 1'b1;
        repeat (3) @(negedge clk_chipset);
        check_value("bios_access_request", 32'(bios_access_request), 1);
        check_value("ioctl_wait", 32'(ioctl_wait), 1);
        check_value("bios_protect_flag", 32'(bios_protect_flag), 1);
        reject_byte(8'd0, 25'h0000100, 8'h44, 1'b1);
        @(posedge clk_chipset);
        bus_granted <= 1'b1;
        write_byte(8'd0, 25'h0000100, 8'h44);
        end_download();
    endtask

    task automatic random_stream();
        logic [31:0] index_bits;
        logic [31:0] addr_bits;
        logic [31:0] data_bits;
        start_download();
        for (int i = 0; i < num_random; i++)
        begin
            random_bits(2, index_bits);
            if (index_bits[1:0] == 2'd3)
                random_bits(`LOAD_ADDR_W, addr_bits);
            else
                random_bits(16, addr_bits);
            random_bits(8, data_bits);
            write_byte(`INDEX_W'(index_bits[1:0]), addr_bits[`LOAD_ADDR_W-1:0],
                       data_bits[7:0]);
        end
        end_download();
    endtask

    initial
    begin
        checks = 0;
        errors = 0;
        lfsr = 16'h0001;
        reset = 1'b1;
        ioctl_download = 1'b0;
        ioctl_index = '0;
        ioctl_addr = '0;
        ioctl_wr = 1'b0;
        ioctl_data = '0;
        bus_granted = 1'b1;
        mem_ready = 1'b1;
        repeat (8) @(posedge clk_chipset);
        reset <= 1'b0;

        reset_values();
        image_mapping();
        rejected_bytes();
        bus_gating();
        random_stream();

        assert_errors = dut.u_asserts.grant_failures + dut.u_asserts.hold_failures +
                        dut.u_asserts.length_failures;
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, assert_errors);
        if (errors == 0 && assert_errors == 0)
        begin
            $display("Test passed");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

    // run limit
    initial
    begin
        cycle_count = 0;
        while (cycle_count < cycle_limit)
        begin
            @(posedge clk_chipset);
            cycle_count++;
        end
        $display("timeout, run did not finish within %0d cycles", cycle_limit);
        $display("Test failed");
        $finish;
    end

endmodule

/* bios_loader_top.f */
+incdir+include
hw/bios_loader_pkg.sv
hw/bios_load_fsm.sv
hw/bios_write_timer.sv
hw/bios_address_map.sv
hw/bios_loader_top.sv
test/bios_loader_asserts.sv
test/bios_loader_tb.sv

/* Makefile */
# Verilator build and run of the firmware image loader testbench

TOP := bios_loader_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module $(TOP) -f bios_loader_top.f
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "Test passed"

clean:
	rm -rf obj_dir
